/* logic/div_bit_counter.sv */
////////////////////////////////////////////////////////////
// Quotient bit position counter
// Loaded with the top index, then stepped down once per
// subtract-and-shift cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "div_config.svh"

module div_bit_counter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      load_i,
  input  logic                      dec_i,
  output logic [`DIV_CNT_WIDTH-1:0] bit_idx_o,
  output logic                      last_o
);

  logic [`DIV_CNT_WIDTH-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= `DIV_CNT_WIDTH'(`DIV_LAST_BIT);
    end else if (dec_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign bit_idx_o = cnt_q;

  // Index one marks the final COMP cycle
  assign last_o = (cnt_q == `DIV_CNT_WIDTH'(1));

  // A wrap would restart the loop behind the FSM's back
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_i |-> (cnt_q != '0));

endmodule

/* logic/div_config.svh */
////////////////////////////////////////////////////////////
// Width and iteration settings for the serial divider
// Included by every RTL file that sizes a bus or a counter
////////////////////////////////////////////////////////////

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand and result width
`define DIV_WIDTH 32

// Bit index counter width
`define DIV_CNT_WIDTH 5

// First quotient bit produced by the restoring loop
`define DIV_LAST_BIT 31

`endif

/* logic/div_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// Internal control phases of the serial divider
// Produced by the FSM and decoded by the datapath
////////////////////////////////////////////////////////////

package div_ctrl_pkg;

  // One phase per cycle of a division run
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    ABS_A       = 3'd1,
    ABS_B       = 3'd2,
    COMP        = 3'd3,
    LAST        = 3'd4,
    CHANGE_SIGN = 3'd5,
    FINISH      = 3'd6
  } div_phase_e;

endpackage

/* logic/div_datapath.sv */
////////////////////////////////////////////////////////////
// Divider datapath with operand, remainder, quotient and
// denominator registers around one shared subtractor
// Register updates are picked by the current FSM phase
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "div_config.svh"

module div_datapath (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_fire_i,
  input  div_ctrl_pkg::div_phase_e  phase_i,
  input  logic [`DIV_CNT_WIDTH-1:0] bit_idx_i,
  input  div_op_pkg::div_op_e       op_i,
  input  logic [`DIV_WIDTH-1:0]     dividend_i,
  input  logic [`DIV_WIDTH-1:0]     divisor_i,
  input  logic                      data_ind_timing_i,
  output logic                      divisor_zero_o,
  output logic                      timing_mode_o,
  output logic [`DIV_WIDTH-1:0]     result_o
);

  div_op_pkg::div_op_e       op_q;
  logic                      timing_q;
  logic                      sign_a_q;
  logic                      sign_b_q;
  logic [`DIV_WIDTH-1:0]     num_q;
  logic [`DIV_WIDTH-1:0]     den_q;
  logic [`DIV_WIDTH-1:0]     rem_q;
  logic [`DIV_WIDTH-1:0]     quot_q;
  logic [`DIV_WIDTH-1:0]     sub_a;
  logic [`DIV_WIDTH-1:0]     sub_b;
  logic [`DIV_WIDTH-1:0]     diff;
  logic                      is_greater_equal;
  logic [`DIV_WIDTH-1:0]     next_rem;
  logic [`DIV_WIDTH-1:0]     quot_base;
  logic [`DIV_WIDTH-1:0]     one_shift;
  logic [`DIV_WIDTH-1:0]     next_quot;
  logic [`DIV_CNT_WIDTH-1:0] num_idx;
  logic                      is_rem;
  logic                      change_sign;

  ////////////////////////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q     <= div_op_pkg::DIV;
      timing_q <= 1'b0;
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
    end else if (req_fire_i) begin
      op_q     <= op_i;
      timing_q <= data_ind_timing_i;
      // Unsigned ops never see a negative operand
      sign_a_q <= dividend_i[`DIV_WIDTH-1] & ~op_i[0];
      sign_b_q <= divisor_i[`DIV_WIDTH-1] & ~op_i[0];
    end
  end

  assign is_rem = op_q[1];

  ////////////////////////////////////////////////////////////
  // Shared subtractor
  ////////////////////////////////////////////////////////////

  always_comb begin
    sub_a = '0;
    sub_b = rem_q;
    unique case (phase_i)
      div_ctrl_pkg::ABS_A: sub_b = num_q;
      div_ctrl_pkg::ABS_B: sub_b = den_q;
      div_ctrl_pkg::COMP, div_ctrl_pkg::LAST: begin
        sub_a = rem_q;
        sub_b = den_q;
      end
      default: ;
    endcase
  end

  assign diff = sub_a - sub_b;

  // Unsigned compare from the MSBs and the difference sign
  always_comb begin
    if (rem_q[`DIV_WIDTH-1] == den_q[`DIV_WIDTH-1]) begin
      is_greater_equal = ~diff[`DIV_WIDTH-1];
    end else begin
      is_greater_equal = rem_q[`DIV_WIDTH-1];
    end
  end

  assign next_rem  = is_greater_equal ? diff : rem_q;
  assign one_shift = {{(`DIV_WIDTH-1){1'b0}}, 1'b1} << bit_idx_i;
  // First COMP step starts from an empty quotient
  assign quot_base = (bit_idx_i == `DIV_CNT_WIDTH'(`DIV_LAST_BIT)) ? '0 : quot_q;
  assign next_quot = is_greater_equal ? (quot_base | one_shift) : quot_base;
  assign num_idx   = bit_idx_i - 1'b1;

  // Quotient sign flip is suppressed for a zero divisor
  assign divisor_zero_o = (den_q == '0);
  assign change_sign    = is_rem ? sign_a_q : ((sign_a_q ^ sign_b_q) & ~divisor_zero_o);

  ////////////////////////////////////////////////////////////
  // Working registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_fire_i) begin
      num_q <= dividend_i;
      den_q <= divisor_i;
      // Preset doubles as the zero divisor result
      rem_q <= op_i[1] ? dividend_i : '1;
    end else begin
      unique case (phase_i)
        div_ctrl_pkg::ABS_A: begin
          if (sign_a_q) begin
            num_q <= diff;
          end
        end
        div_ctrl_pkg::ABS_B: begin
          if (sign_b_q) begin
            den_q <= diff;
          end
          rem_q <= {{(`DIV_WIDTH-1){1'b0}}, num_q[`DIV_WIDTH-1]};
        end
        div_ctrl_pkg::COMP: begin
          rem_q  <= {next_rem[`DIV_WIDTH-2:0], num_q[num_idx]};
          quot_q <= next_quot;
        end
        // Remainder register now carries the selected result
        div_ctrl_pkg::LAST: rem_q <= is_rem ? next_rem : next_quot;
        div_ctrl_pkg::CHANGE_SIGN: begin
          if (change_sign) begin
            rem_q <= diff;
          end
        end
        default: ;
      endcase
    end
  end

  assign timing_mode_o = timing_q;
  assign result_o      = rem_q;

  // Each restoring step leaves less than the divisor behind
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((phase_i == div_ctrl_pkg::COMP || phase_i == div_ctrl_pkg::LAST) && (den_q != '0))
      |-> (next_rem < den_q));

endmodule

/* logic/div_fsm.sv */
////////////////////////////////////////////////////////////
// Phase sequencer of the serial divider
// Owns the request and result valid/ready handshakes and
// steers the bit counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "div_config.svh"

module div_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  input  logic                     res_ready_i,
  input  logic                     divisor_zero_i,
  input  logic                     data_ind_timing_i,
  input  logic                     last_i,
  output div_ctrl_pkg::div_phase_e phase_o,
  output logic                     req_ready_o,
  output logic                     res_valid_o,
  output logic                     cnt_load_o,
  output logic                     cnt_dec_o
);

  div_ctrl_pkg::div_phase_e phase_q, phase_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= div_ctrl_pkg::IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next phase
  ////////////////////////////////////////////////////////////

  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      div_ctrl_pkg::IDLE: begin
        if (req_valid_i) begin
          phase_d = div_ctrl_pkg::ABS_A;
        end
      end
      div_ctrl_pkg::ABS_A: begin
        // Zero divisor skips the run unless timing must not leak
        if (divisor_zero_i && !data_ind_timing_i) begin
          phase_d = div_ctrl_pkg::FINISH;
        end else begin
          phase_d = div_ctrl_pkg::ABS_B;
        end
      end
      div_ctrl_pkg::ABS_B: phase_d = div_ctrl_pkg::COMP;
      div_ctrl_pkg::COMP: begin
        if (last_i) begin
          phase_d = div_ctrl_pkg::LAST;
        end
      end
      div_ctrl_pkg::LAST:        phase_d = div_ctrl_pkg::CHANGE_SIGN;
      div_ctrl_pkg::CHANGE_SIGN: phase_d = div_ctrl_pkg::FINISH;
      div_ctrl_pkg::FINISH: begin
        // Result held until the consumer takes it
        if (res_ready_i) begin
          phase_d = div_ctrl_pkg::IDLE;
        end
      end
      default: phase_d = div_ctrl_pkg::IDLE;
    endcase
  end

  assign phase_o     = phase_q;
  assign req_ready_o = (phase_q == div_ctrl_pkg::IDLE);
  assign res_valid_o = (phase_q == div_ctrl_pkg::FINISH);
  // Counter holds the top bit index when COMP starts
  assign cnt_load_o  = (phase_q == div_ctrl_pkg::ABS_B);
  assign cnt_dec_o   = (phase_q == div_ctrl_pkg::COMP);

  // Back-pressure keeps the result offered
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_valid_o && !res_ready_i) |=> res_valid_o);

  // Counter ends the loop after one COMP cycle per upper quotient bit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cnt_dec_o) |-> ##`DIV_LAST_BIT $fell(cnt_dec_o));

endmodule

/* logic/div_op_pkg.sv */
////////////////////////////////////////////////////////////
// Operation encoding seen at the divider request port
// Shared by the top level, the datapath and the testbench
////////////////////////////////////////////////////////////

package div_op_pkg;

  // Upper bit picks the remainder, lower bit picks unsigned
  typedef enum logic [1:0] {
    DIV  = 2'b00,
    DIVU = 2'b01,
    REM  = 2'b10,
    REMU = 2'b11
  } div_op_e;

endpackage

/* logic/serial_divider.sv */
////////////////////////////////////////////////////////////
// Serial radix-2 divider for 32-bit signed and unsigned
// divide and remainder, one operation at a time behind a
// valid/ready request port and a valid/ready result port
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "div_config.svh"

module serial_divider (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  div_op_pkg::div_op_e   op_i,
  input  logic [`DIV_WIDTH-1:0] dividend_i,
  input  logic [`DIV_WIDTH-1:0] divisor_i,
  input  logic                  data_ind_timing_i,
  input  logic                  res_ready_i,
  output logic                  req_ready_o,
  output logic                  res_valid_o,
  output logic [`DIV_WIDTH-1:0] result_o
);

  div_ctrl_pkg::div_phase_e  phase;
  logic                      req_fire;
  logic                      cnt_load;
  logic                      cnt_dec;
  logic                      cnt_last;
  logic [`DIV_CNT_WIDTH-1:0] bit_idx;
  logic                      divisor_zero;
  logic                      timing_mode;

  assign req_fire = req_valid_i & req_ready_o;

  div_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .res_ready_i       (res_ready_i),
    .divisor_zero_i    (divisor_zero),
    .data_ind_timing_i (timing_mode),
    .last_i            (cnt_last),
    .phase_o           (phase),
    .req_ready_o       (req_ready_o),
    .res_valid_o       (res_valid_o),
    .cnt_load_o        (cnt_load),
    .cnt_dec_o         (cnt_dec)
  );

  div_bit_counter u_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (cnt_load),
    .dec_i     (cnt_dec),
    .bit_idx_o (bit_idx),
    .last_o    (cnt_last)
  );

  div_datapath u_datapath (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_fire_i        (req_fire),
    .phase_i           (phase),
    .bit_idx_i         (bit_idx),
    .op_i              (op_i),
    .dividend_i        (dividend_i),
    .divisor_i         (divisor_i),
    .data_ind_timing_i (data_ind_timing_i),
    .divisor_zero_o    (divisor_zero),
    .timing_mode_o     (timing_mode),
    .result_o          (result_o)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the divider testbench with Verilator and runs it
# The verdict comes from searching the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_serial_divider \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_serial_divider > sim.log 2>&1 || true
cat sim.log

grep -q "Checks failed" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

/* testbench/divider_stimulus.txt */
// op dividend divisor timing expected, all fields hex
// op 0 DIV, 1 DIVU, 2 REM, 3 REMU and timing 1 keeps the full run on a zero divisor
0 00000064 00000007 0 0000000e
0 ffffff9c 00000007 0 fffffff2
0 00000064 fffffff9 0 fffffff2
0 ffffff9c fffffff9 0 0000000e
2 00000064 00000007 0 00000002
2 ffffff9c 00000007 0 fffffffe
2 00000064 fffffff9 0 00000002
2 ffffff9c fffffff9 0 fffffffe
1 ffffff9c 00000007 0 24924916
3 ffffff9c 00000007 0 00000002
1 12345678 00001000 0 00012345
3 12345678 00001000 0 00000678
1 ffffffff 80000001 0 00000001
3 ffffffff 80000001 0 7ffffffe
0 7fffffff 00000010 1 07ffffff
0 80000000 ffffffff 0 80000000
2 80000000 ffffffff 0 00000000
0 80000000 80000000 0 00000001
2 00000007 80000000 0 00000007
0 12345678 00000000 0 ffffffff
1 12345678 00000000 0 ffffffff
2 87654321 00000000 0 87654321
3 87654321 00000000 0 87654321
0 87654321 00000000 1 ffffffff
1 00000005 00000000 1 ffffffff
2 87654321 00000000 1 87654321
3 00000005 00000000 1 00000005

/* testbench/tb_serial_divider.sv */
////////////////////////////////////////////////////////////
// Testbench for the serial divider
// Replays the vectors of the stimulus file with random
// result back-pressure and checks values and latency
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "div_config.svh"

module tb_serial_divider;

  localparam int clk_half_ns       = 5;
  localparam int clk_period_ns     = 2 * clk_half_ns;
  localparam int reset_cycles      = 8;
  // ABS_A, ABS_B, 31 COMP, LAST and CHANGE_SIGN
  localparam int full_latency      = `DIV_LAST_BIT + 4;
  localparam int fast_latency      = 1;
  localparam int cycles_per_vector = 60;
  localparam int margin_cycles     = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid;
  div_op_pkg::div_op_e   req_op;
  logic [`DIV_WIDTH-1:0] req_dividend;
  logic [`DIV_WIDTH-1:0] req_divisor;
  logic                  req_timing;
  logic                  res_ready;
  logic                  req_ready;
  logic                  res_valid;
  logic [`DIV_WIDTH-1:0] result;

  // Vectors as read from the stimulus file
  div_op_pkg::div_op_e   vec_op[$];
  logic [`DIV_WIDTH-1:0] vec_a[$];
  logic [`DIV_WIDTH-1:0] vec_b[$];
  logic                  vec_timing[$];
  logic [`DIV_WIDTH-1:0] vec_exp[$];
  logic                  vectors_loaded;
  int                    watchdog_ns;

  serial_divider uut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .req_valid_i       (req_valid),
    .op_i              (req_op),
    .dividend_i        (req_dividend),
    .divisor_i         (req_divisor),
    .data_ind_timing_i (req_timing),
    .res_ready_i       (res_ready),
    .req_ready_o       (req_ready),
    .res_valid_o       (res_valid),
    .result_o          (result)
  );

  initial clk = 1'b0;

  always #clk_half_ns clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_result(input div_op_pkg::div_op_e op,
                              input logic [`DIV_WIDTH-1:0] got,
                              input logic [`DIV_WIDTH-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL t=%0t result_o (%s) got=%h expected=%h",
                          $time, op.name(), got, exp));
    end
  endtask

  task automatic check_latency(input div_op_pkg::div_op_e op, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("FAIL t=%0t res_valid_o latency (%s) got=%0d expected=%0d",
                          $time, op.name(), got, exp));
    end
  endtask

  task automatic verify_handshake(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL t=%0t %s got=%b expected=%b", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Vector file and per-vector sequence
  ////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int                    fd;
    int                    fields;
    string                 line;
    logic [3:0]            op_v;
    logic [`DIV_WIDTH-1:0] a_v;
    logic [`DIV_WIDTH-1:0] b_v;
    logic [3:0]            t_v;
    logic [`DIV_WIDTH-1:0] e_v;
    fd = $fopen("testbench/divider_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open testbench/divider_stimulus.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Column notes start with two slashes
      if (!(line.len() >= 2 && line.substr(0, 1) == "//")) begin
        fields = $sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, t_v, e_v);
        if (fields == 5) begin
          vec_op.push_back(div_op_pkg::div_op_e'(op_v[1:0]));
          vec_a.push_back(a_v);
          vec_b.push_back(b_v);
          vec_timing.push_back(t_v[0]);
          vec_exp.push_back(e_v);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int idx);
    div_op_pkg::div_op_e   op;
    logic [`DIV_WIDTH-1:0] exp;
    logic [31:0]           rnd;
    int                    exp_latency;
    int                    latency;
    int                    hold;
    op  = vec_op[idx];
    exp = vec_exp[idx];
    // Shortcut only for a zero divisor outside constant-time mode
    if (vec_b[idx] == '0 && !vec_timing[idx]) begin
      exp_latency = fast_latency;
    end else begin
      exp_latency = full_latency;
    end
    @(posedge clk);
    #1;
    req_valid    = 1'b1;
    req_op       = op;
    req_dividend = vec_a[idx];
    req_divisor  = vec_b[idx];
    req_timing   = vec_timing[idx];
    @(negedge clk);
    while (!req_ready) begin
      @(posedge clk);
      @(negedge clk);
    end
    // Inputs scrambled after the accept edge to show they were latched
    @(posedge clk);
    #1;
    rnd          = $urandom;
    req_valid    = 1'b0;
    req_op       = div_op_pkg::div_op_e'(rnd[2:1]);
    req_timing   = rnd[0];
    req_dividend = $urandom;
    req_divisor  = $urandom;
    latency      = 0;
    do begin
      @(posedge clk);
      latency = latency + 1;
      @(negedge clk);
      if (!res_valid) begin
        verify_handshake("req_ready_o", req_ready, 1'b0);
      end
    end while (!res_valid);
    check_latency(op, latency, exp_latency);
    check_result(op, result, exp);
    // Back-pressure while the result is offered
    hold = int'($urandom % 6);
    repeat (hold) begin
      @(posedge clk);
      @(negedge clk);
      verify_handshake("res_valid_o", res_valid, 1'b1);
      verify_handshake("req_ready_o", req_ready, 1'b0);
      check_result(op, result, exp);
    end
    @(posedge clk);
    #1;
    res_ready = 1'b1;
    @(negedge clk);
    verify_handshake("res_valid_o", res_valid, 1'b1);
    check_result(op, result, exp);
    @(posedge clk);
    #1;
    res_ready = 1'b0;
    @(negedge clk);
    verify_handshake("req_ready_o", req_ready, 1'b1);
    verify_handshake("res_valid_o", res_valid, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin : main_seq
    vectors_loaded = 1'b0;
    void'($urandom(32'h8d4b));
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_op       = div_op_pkg::DIV;
    req_dividend = '0;
    req_divisor  = '0;
    req_timing   = 1'b0;
    res_ready    = 1'b0;
    load_vectors();
    if (vec_op.size() == 0) begin
      abort_run("No vectors found in the stimulus file");
    end
    watchdog_ns = (vec_op.size() * cycles_per_vector + reset_cycles + margin_cycles)
                  * clk_period_ns;
    vectors_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    verify_handshake("req_ready_o", req_ready, 1'b1);
    verify_handshake("res_valid_o", res_valid, 1'b0);
    for (int i = 0; i < vec_op.size(); i++) begin
      run_vector(i);
    end
    $display("All checks passed");
    $finish;
  end

  initial begin : watchdog
    wait (vectors_loaded === 1'b1);
    #(watchdog_ns);
    abort_run("Watchdog expired before all vectors completed");
  end

endmodule

/* verilog.f */
+incdir+logic
logic/div_op_pkg.sv
logic/div_ctrl_pkg.sv
logic/div_fsm.sv
logic/div_bit_counter.sv
logic/div_datapath.sv
logic/serial_divider.sv
testbench/tb_serial_divider.sv
